// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
    --top-module tb_trigger_top -f trigger_top.f -o tb_sim
./obj_dir/tb_sim > sim.log
cat sim.log
if grep -q "Finished with errors" sim.log; then
    echo "simulation failed"
    exit 1
fi
grep -q "Finished with no errors" sim.log
echo "simulation passed"

// File: source/channel_acq_controller.sv
// channel acquisition controller: delays the trigger, fans it out, collects dones
`default_nettype none

module channel_acq_controller (
    input  logic                    ttc_clk,
    input  logic                    rst,
    input  logic                    acq_trigger, // one-cycle pulse
    input  trigger_pkg::chan_mask_t chan_en,
    input  trigger_pkg::delay_t     trig_delay,
    input  trigger_pkg::chan_mask_t chan_dones,
    output trigger_pkg::chan_mask_t chan_trig,
    output logic                    acq_ready
);
    import trigger_pkg::*;

    cac_state_t state;
    delay_t     delay_cnt;
    chan_mask_t mask; // chan_en at the trigger

    assign acq_ready = (state == CAC_IDLE);

    // fires trig_delay+1 cycles after acq_trigger
    assign chan_trig = (state == CAC_DELAY && delay_cnt == '0) ? mask : '0;

    always_ff @(posedge ttc_clk) begin
        if (rst) begin
            state <= CAC_IDLE;
        end else begin
            case (state)
                CAC_IDLE: begin
                    if (acq_trigger) begin
                        state <= CAC_DELAY;
                    end
                end
                CAC_DELAY: begin
                    if (delay_cnt == '0) begin
                        state <= CAC_WAIT_DONE;
                    end
                end
                CAC_WAIT_DONE: begin
                    // all enabled channels done together
                    if ((chan_dones & mask) == mask) begin
                        state <= CAC_IDLE;
                    end
                end
                default: state <= CAC_IDLE;
            endcase
        end
    end

    // delay count and latched mask
    always_ff @(posedge ttc_clk) begin
        if (state == CAC_IDLE && acq_trigger) begin
            delay_cnt <= trig_delay;
            mask      <= chan_en;
        end else if (state == CAC_DELAY && delay_cnt != '0) begin
            delay_cnt <= delay_cnt - 1'b1;
        end
    end

    // ----------------------------------------------------------------------
    // checks
    // ----------------------------------------------------------------------
    a_trig_in_mask : assert property (@(posedge ttc_clk) disable iff (rst)
        (chan_trig & ~mask) == '0);

    // receiver must only trigger an idle controller
    a_trig_when_idle : assert property (@(posedge ttc_clk) disable iff (rst)
        acq_trigger |-> state == CAC_IDLE);

endmodule

`default_nettype wire

// File: source/pulse_trigger_receiver.sv
// front panel trigger receiver: gates pulses, sorts them by width, timestamps them
`default_nettype none

module pulse_trigger_receiver (
    input  logic                    ttc_clk,
    input  logic                    rst,
    input  logic                    ext_trigger,           // level
    input  logic                    accept_pulse_triggers,
    input  trigger_pkg::width_t     fp_trig_width,         // short/long split
    input  trigger_pkg::timestamp_t timestamp,
    trig_record_if.source           rec
);
    import trigger_pkg::*;

    ptr_state_t state;
    logic       ext_prev;
    logic       rise;
    width_t     high_cnt; // saturates at all ones
    trig_num_t  next_num;

    assign rise      = ext_trigger && !ext_prev;
    assign rec.valid = (state == PTR_PENDING);

    always_ff @(posedge ttc_clk) begin
        if (rst) begin
            state    <= PTR_IDLE;
            ext_prev <= 1'b0;
            next_num <= trig_num_t'(1);
        end else begin
            ext_prev <= ext_trigger;
            case (state)
                PTR_IDLE: begin
                    if (rise && accept_pulse_triggers) begin
                        state <= PTR_HIGH;
                    end
                end
                PTR_HIGH: begin
                    if (!ext_trigger) begin // falling edge
                        state    <= PTR_PENDING;
                        next_num <= next_num + 1'b1;
                    end
                end
                PTR_PENDING: begin
                    if (rec.grant) begin
                        state <= PTR_IDLE;
                    end
                end
                default: state <= PTR_IDLE;
            endcase
        end
    end

    // ----------------------------------------------------------------------
    // width measurement and record fields
    // ----------------------------------------------------------------------
    always_ff @(posedge ttc_clk) begin
        if (state == PTR_IDLE && rise) begin
            rec.timestamp <= timestamp;
            high_cnt      <= width_t'(1); // first high cycle
        end else if (state == PTR_HIGH) begin
            if (ext_trigger) begin
                if (high_cnt != '1) begin
                    high_cnt <= high_cnt + 1'b1;
                end
            end else begin
                rec.num       <= next_num;
                rec.trig_type <= (high_cnt >= fp_trig_width) ? TRIG_TYPE_PULSE_LONG
                                                             : TRIG_TYPE_PULSE_SHORT;
            end
        end
    end

endmodule

`default_nettype wire

// File: source/trig_record_if.sv
// trigger record link from a receiver to the record arbiter
`default_nettype none

interface trig_record_if;
    import trigger_pkg::*;

    logic       valid;     // record presented, fields stable
    logic       grant;     // transfer happens this cycle
    trig_num_t  num;
    trig_type_t trig_type;
    timestamp_t timestamp;

    // receiver side
    modport source (
        output valid,
        output num,
        output trig_type,
        output timestamp,
        input  grant
    );

    modport arbiter (
        input  valid,
        input  num,
        input  trig_type,
        input  timestamp,
        output grant
    );

endinterface

`default_nettype wire

// File: source/trigger_pkg.sv
// trigger path package: widths, record codes, FIFO sizing and FSM states
`default_nettype none

package trigger_pkg;

    // ----------------------------------------------------------------------
    // field widths
    // ----------------------------------------------------------------------
    localparam int NUM_CHAN   = 5;
    localparam int TRIG_NUM_W = 24;
    localparam int TS_W       = 44; // ~5 days of 40 MHz ticks
    localparam int TYPE_W     = 5;
    localparam int DELAY_W    = 16;
    localparam int WIDTH_W    = 4;

    typedef logic [TRIG_NUM_W-1:0] trig_num_t;  // starts at 1
    typedef logic [TS_W-1:0]       timestamp_t; // in ttc_clk cycles
    typedef logic [TYPE_W-1:0]     trig_type_t;
    typedef logic [NUM_CHAN-1:0]   chan_mask_t; // one bit per channel
    typedef logic [DELAY_W-1:0]    delay_t;
    typedef logic [WIDTH_W-1:0]    width_t;     // pulse width threshold

    // front panel type codes
    localparam trig_type_t TRIG_TYPE_PULSE_SHORT = 5'h08;
    localparam trig_type_t TRIG_TYPE_PULSE_LONG  = 5'h09;

    // record source tag
    localparam logic SRC_TTC   = 1'b0;
    localparam logic SRC_PULSE = 1'b1;

    // ----------------------------------------------------------------------
    // record FIFO
    // ----------------------------------------------------------------------
    localparam int FIFO_DEPTH       = 16;
    localparam int FIFO_ALMOST_FULL = 14;
    localparam int FIFO_PTR_W       = $clog2(FIFO_DEPTH);

    typedef logic [FIFO_PTR_W-1:0] fifo_ptr_t;
    typedef logic [FIFO_PTR_W:0]   fifo_cnt_t; // one extra bit, holds DEPTH

    // ----------------------------------------------------------------------
    // state machines
    // ----------------------------------------------------------------------
    typedef enum logic {
        TTR_IDLE,
        TTR_PENDING  // record waits for grant
    } ttr_state_t;

    typedef enum logic [1:0] {
        PTR_IDLE,
        PTR_HIGH,    // pulse in progress
        PTR_PENDING
    } ptr_state_t;

    typedef enum logic [1:0] {
        CAC_IDLE,
        CAC_DELAY,
        CAC_WAIT_DONE
    } cac_state_t;

endpackage

`default_nettype wire

// File: source/trigger_record_arbiter.sv
// record arbiter: TTC over pulse, one grant per cycle into the shared FIFO
`default_nettype none

module trigger_record_arbiter (
    trig_record_if.arbiter           ttc_rec,
    trig_record_if.arbiter           pulse_rec,
    input  logic                     fifo_full,
    output logic                     wr_en,
    output logic                     wr_source,
    output trigger_pkg::trig_num_t   wr_num,
    output trigger_pkg::trig_type_t  wr_type,
    output trigger_pkg::timestamp_t  wr_timestamp
);
    import trigger_pkg::*;

    // fixed priority, nothing while full
    assign ttc_rec.grant   = ttc_rec.valid && !fifo_full;
    assign pulse_rec.grant = pulse_rec.valid && !ttc_rec.valid && !fifo_full;

    assign wr_en     = ttc_rec.grant || pulse_rec.grant;
    assign wr_source = ttc_rec.valid ? SRC_TTC : SRC_PULSE;

    // winner's fields
    always_comb begin
        if (ttc_rec.valid) begin
            wr_num       = ttc_rec.num;
            wr_type      = ttc_rec.trig_type;
            wr_timestamp = ttc_rec.timestamp;
        end else begin
            wr_num       = pulse_rec.num;
            wr_type      = pulse_rec.trig_type;
            wr_timestamp = pulse_rec.timestamp;
        end
    end

    always_comb begin
        a_one_grant : assert (!(ttc_rec.grant && pulse_rec.grant));
    end

endmodule

`default_nettype wire

// File: source/trigger_record_fifo.sv
// trigger record FIFO: register array, first-word fall-through, almost-full flag
`default_nettype none

module trigger_record_fifo (
    input  logic                    ttc_clk,
    input  logic                    rst,
    input  logic                    wr_en,
    input  logic                    wr_source,
    input  trigger_pkg::trig_num_t  wr_num,
    input  trigger_pkg::trig_type_t wr_type,
    input  trigger_pkg::timestamp_t wr_timestamp,
    output logic                    full,
    output logic                    almost_full,
    input  logic                    rd_ready,
    output logic                    rd_valid,
    output logic                    rd_source,
    output trigger_pkg::trig_num_t  rd_num,
    output trigger_pkg::trig_type_t rd_type,
    output trigger_pkg::timestamp_t rd_timestamp
);
    import trigger_pkg::*;

    logic       src_mem [FIFO_DEPTH];
    trig_num_t  num_mem [FIFO_DEPTH];
    trig_type_t type_mem[FIFO_DEPTH];
    timestamp_t ts_mem  [FIFO_DEPTH];

    fifo_ptr_t wr_ptr;
    fifo_ptr_t rd_ptr;
    fifo_cnt_t count; // occupancy
    logic      rd_en;

    assign rd_valid    = (count != '0);
    assign rd_en       = rd_valid && rd_ready;
    assign full        = (count == fifo_cnt_t'(FIFO_DEPTH));
    assign almost_full = (count >= fifo_cnt_t'(FIFO_ALMOST_FULL));

    always_ff @(posedge ttc_clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) wr_ptr <= wr_ptr + 1'b1;
            if (rd_en) rd_ptr <= rd_ptr + 1'b1;
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count; // both or neither
            endcase
        end
    end

    always_ff @(posedge ttc_clk) begin
        if (wr_en) begin
            src_mem[wr_ptr]  <= wr_source;
            num_mem[wr_ptr]  <= wr_num;
            type_mem[wr_ptr] <= wr_type;
            ts_mem[wr_ptr]   <= wr_timestamp;
        end
    end

    // head entry
    assign rd_source    = src_mem[rd_ptr];
    assign rd_num       = num_mem[rd_ptr];
    assign rd_type      = type_mem[rd_ptr];
    assign rd_timestamp = ts_mem[rd_ptr];

    // arbiter holds off on full
    a_no_write_full : assert property (@(posedge ttc_clk) disable iff (rst)
        wr_en |-> !full);

endmodule

`default_nettype wire

// File: source/trigger_top.sv
// trigger path top: TTC and pulse receivers, channel control, shared record FIFO
`default_nettype none

module trigger_top (
    input  logic                    ttc_clk,               // 40 MHz
    input  logic                    rst,
    // trigger inputs
    input  logic                    ttc_trigger,
    input  logic                    ext_trigger,
    input  logic                    accept_pulse_triggers,
    input  trigger_pkg::trig_type_t trig_type,
    input  trigger_pkg::chan_mask_t chan_en,
    input  trigger_pkg::delay_t     trig_delay,
    input  trigger_pkg::width_t     fp_trig_width,
    // channels
    input  trigger_pkg::chan_mask_t chan_dones,
    output trigger_pkg::chan_mask_t chan_trig,
    output logic                    acq_ready,
    // record readout
    input  logic                    rec_ready,
    output logic                    rec_valid,
    output logic                    rec_source,
    output trigger_pkg::trig_type_t rec_type,
    output trigger_pkg::trig_num_t  rec_num,
    output trigger_pkg::timestamp_t rec_timestamp,
    output logic                    fifo_almost_full,
    output logic                    error_trig_rate
);
    import trigger_pkg::*;

    // ----------------------------------------------------------------------
    // internal nets
    // ----------------------------------------------------------------------
    logic       acq_trigger;
    timestamp_t timestamp;
    logic       fifo_full;
    logic       wr_en;
    logic       wr_source;
    trig_num_t  wr_num;
    trig_type_t wr_type;
    timestamp_t wr_timestamp;

    trig_record_if ttc_rec ();
    trig_record_if pulse_rec ();

    ttc_trigger_receiver u_ttc_rx (
        .ttc_clk(ttc_clk), .rst(rst),
        .ttc_trigger(ttc_trigger),
        .trig_type(trig_type),
        .acq_ready(acq_ready),
        .acq_trigger(acq_trigger),
        .timestamp(timestamp),
        .rec(ttc_rec.source),
        .error_trig_rate(error_trig_rate)
    );

    pulse_trigger_receiver u_pulse_rx (
        .ttc_clk(ttc_clk), .rst(rst),
        .ext_trigger(ext_trigger),
        .accept_pulse_triggers(accept_pulse_triggers),
        .fp_trig_width(fp_trig_width),
        .timestamp(timestamp),           // shared time base
        .rec(pulse_rec.source)
    );

    channel_acq_controller u_cac (
        .ttc_clk(ttc_clk), .rst(rst),
        .acq_trigger(acq_trigger),
        .chan_en(chan_en),
        .trig_delay(trig_delay),
        .chan_dones(chan_dones),
        .chan_trig(chan_trig),
        .acq_ready(acq_ready)
    );

    trigger_record_arbiter u_arb (
        .ttc_rec(ttc_rec.arbiter),
        .pulse_rec(pulse_rec.arbiter),
        .fifo_full(fifo_full),
        .wr_en(wr_en), .wr_source(wr_source),
        .wr_num(wr_num), .wr_type(wr_type), .wr_timestamp(wr_timestamp)
    );

    trigger_record_fifo u_fifo (
        .ttc_clk(ttc_clk), .rst(rst),
        .wr_en(wr_en), .wr_source(wr_source),
        .wr_num(wr_num), .wr_type(wr_type), .wr_timestamp(wr_timestamp),
        .full(fifo_full),
        .almost_full(fifo_almost_full),
        .rd_ready(rec_ready), .rd_valid(rec_valid), .rd_source(rec_source),
        .rd_num(rec_num), .rd_type(rec_type), .rd_timestamp(rec_timestamp)
    );

endmodule

`default_nettype wire

// File: source/ttc_trigger_receiver.sv
// TTC trigger receiver: admits backplane triggers, numbers and timestamps them
`default_nettype none

module ttc_trigger_receiver (
    input  logic                    ttc_clk,
    input  logic                    rst,
    input  logic                    ttc_trigger,     // one-cycle strobe
    input  trigger_pkg::trig_type_t trig_type,
    input  logic                    acq_ready,       // from channel controller
    output logic                    acq_trigger,
    output trigger_pkg::timestamp_t timestamp,       // free-running
    trig_record_if.source           rec,
    output logic                    error_trig_rate  // sticky
);
    import trigger_pkg::*;

    ttr_state_t state;
    trig_num_t  next_num;
    logic       accept;

    // controller ready and no record left waiting
    assign accept    = ttc_trigger && acq_ready && (state == TTR_IDLE || rec.grant);
    assign rec.valid = (state == TTR_PENDING);

    // ----------------------------------------------------------------------
    // control
    // ----------------------------------------------------------------------
    always_ff @(posedge ttc_clk) begin
        if (rst) begin
            state           <= TTR_IDLE;
            timestamp       <= '0;
            next_num        <= trig_num_t'(1);
            acq_trigger     <= 1'b0;
            error_trig_rate <= 1'b0;
        end else begin
            timestamp   <= timestamp + 1'b1;
            acq_trigger <= accept; // one cycle after sampling

            if (accept) begin
                state    <= TTR_PENDING;
                next_num <= next_num + 1'b1;
            end else if (rec.grant) begin
                state <= TTR_IDLE;
            end

            // too soon, dropped
            if (ttc_trigger && !accept) begin
                error_trig_rate <= 1'b1;
            end
        end
    end

    // record fields
    always_ff @(posedge ttc_clk) begin
        if (accept) begin
            rec.num       <= next_num;
            rec.trig_type <= trig_type;
            rec.timestamp <= timestamp; // value at the trigger edge
        end
    end

    // a presented record is only withdrawn by a transfer
    a_valid_held : assert property (@(posedge ttc_clk) disable iff (rst)
        rec.valid && !rec.grant |=> rec.valid);

endmodule

`default_nettype wire

// File: tb/tb_trigger_top.sv
// directed testbench of the trigger path from channel fan-out to record FIFO back-pressure
`default_nettype none

module tb_trigger_top;
    timeunit 1ns;
    timeprecision 100ps;
    import trigger_pkg::*;

    localparam int          CLK_PERIOD      = 100;
    localparam logic [31:0] LFSR_SEED       = 32'h3ecea522;
    localparam int          WATCHDOG_CYCLES = 20000; // all tests need well under 1000

    logic       clk;
    logic       rst;
    logic       ttc_trigger;
    logic       ext_trigger;
    logic       accept_pulse_triggers;
    trig_type_t trig_type;
    chan_mask_t chan_en;
    delay_t     trig_delay;
    width_t     fp_trig_width;
    chan_mask_t chan_dones;
    logic       rec_ready;
    chan_mask_t chan_trig;
    logic       acq_ready;
    logic       rec_valid;
    logic       rec_source;
    trig_type_t rec_type;
    trig_num_t  rec_num;
    timestamp_t rec_timestamp;
    logic       fifo_almost_full;
    logic       error_trig_rate;

    timestamp_t  ts_model;   // mirrors the DUT time base
    trig_num_t   ttc_num;    // next expected TTC number
    trig_num_t   pulse_num;  // next expected pulse number
    logic [31:0] lfsr;
    int          mismatches;
    int          failures;
    logic [73:0] exp_q[$];   // {source, num, type, timestamp}

    trigger_top u_dut (.ttc_clk(clk), .*);

    // ----------------------------------------------------------------------
    // clock, time base, watchdog
    // ----------------------------------------------------------------------
    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // 0 in the first cycle out of reset, +1 per cycle
    always @(posedge clk) begin
        if (rst) begin
            ts_model <= '0;
        end else begin
            ts_model <= ts_model + 44'd1;
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles, run stopped", WATCHDOG_CYCLES);
        $display("Finished with errors");
        $finish;
    end

    // ----------------------------------------------------------------------
    // helpers
    // ----------------------------------------------------------------------
    task automatic report_mismatch(input string name, input logic [63:0] got,
                                   input logic [63:0] exp);
        $display("Mismatch at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
        mismatches++;
    endtask

    task automatic report_failure(input string what);
        $display("Error at %0t ns: %s", $time, what);
        failures++;
    endtask

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1); // galois form
    endfunction

    // one lfsr step per bit taken
    function automatic logic [15:0] rand_bits(input int n);
        logic [15:0] v;
        int          i;
        v = '0;
        for (i = 0; i < n; i++) begin
            v    = {v[14:0], lfsr[0]};
            lfsr = lfsr_step(lfsr);
        end
        return v;
    endfunction

    function automatic logic [73:0] make_rec(input logic src, input trig_num_t num,
                                             input trig_type_t t, input timestamp_t ts);
        return {src, num, t, ts};
    endfunction

    // scoreboard compares each record as it is read out
    always @(negedge clk) begin
        logic [73:0] exp;
        if (!rst && rec_valid && rec_ready) begin
            if (exp_q.size() == 0) begin
                report_failure("record read out that no trigger should have made");
            end else begin
                exp = exp_q.pop_front();
                if (rec_source !== exp[73]) begin
                    report_mismatch("rec_source", 64'(rec_source), 64'(exp[73]));
                end
                if (rec_num !== exp[72:49]) begin
                    report_mismatch("rec_num", 64'(rec_num), 64'(exp[72:49]));
                end
                if (rec_type !== exp[48:44]) begin
                    report_mismatch("rec_type", 64'(rec_type), 64'(exp[48:44]));
                end
                if (rec_timestamp !== exp[43:0]) begin
                    report_mismatch("rec_timestamp", 64'(rec_timestamp), 64'(exp[43:0]));
                end
            end
        end
    end

    // strobe ttc_trigger for one cycle and return just after the sampling edge
    task automatic fire_ttc(input trig_type_t t, input logic accepted);
        @(posedge clk);
        ttc_trigger <= 1'b1;
        trig_type   <= t;
        @(negedge clk);
        if (accepted) begin
            exp_q.push_back(make_rec(SRC_TTC, ttc_num, t, ts_model));
            ttc_num++;
        end
        @(posedge clk);
        ttc_trigger <= 1'b0;
    endtask

    // ext_trigger high for w sampling edges
    task automatic send_pulse(input int w, input logic accepted);
        timestamp_t ts;
        trig_type_t t;
        @(posedge clk);
        ext_trigger <= 1'b1;
        @(negedge clk);
        ts = ts_model;            // value seen at the rising edge
        repeat (w) @(posedge clk);
        ext_trigger <= 1'b0;
        t = (w >= int'(fp_trig_width)) ? TRIG_TYPE_PULSE_LONG : TRIG_TYPE_PULSE_SHORT;
        if (accepted) begin
            exp_q.push_back(make_rec(SRC_PULSE, pulse_num, t, ts));
            pulse_num++;
        end
    endtask

    task automatic wait_acq_ready();
        int n;
        n = 0;
        repeat (2) @(negedge clk); // low from the cycle after acq_trigger
        while (!acq_ready && n < 200) begin
            @(negedge clk);
            n++;
        end
        if (!acq_ready) begin
            report_failure("acq_ready never came back high");
        end
    endtask

    task automatic wait_drained();
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < 500) begin
            @(negedge clk);
            n++;
        end
        if (exp_q.size() != 0) begin
            report_failure($sformatf("%0d expected records never came out", exp_q.size()));
        end
    endtask

    // ----------------------------------------------------------------------
    // tests
    // ----------------------------------------------------------------------
    task automatic check_reset_state();
        @(negedge clk);
        if (acq_ready !== 1'b1) report_mismatch("acq_ready", 64'(acq_ready), 64'd1);
        if (rec_valid !== 1'b0) report_mismatch("rec_valid", 64'(rec_valid), 64'd0);
        if (chan_trig !== '0) report_mismatch("chan_trig", 64'(chan_trig), 64'd0);
        if (fifo_almost_full !== 1'b0) begin
            report_mismatch("fifo_almost_full", 64'(fifo_almost_full), 64'd0);
        end
        if (error_trig_rate !== 1'b0) begin
            report_mismatch("error_trig_rate", 64'(error_trig_rate), 64'd0);
        end
    endtask

    task automatic test_fanout();
        chan_mask_t en;
        chan_mask_t exp_trig;
        int         d;
        int         n;
        en = 5'b10110;
        d  = 3 + int'(rand_bits(3));
        @(posedge clk);
        chan_en    <= en;
        trig_delay <= delay_t'(d);
        chan_dones <= '0;
        fire_ttc(5'h03, 1'b1);
        for (n = 0; n <= d + 2; n++) begin // n = 0 is the acq_trigger cycle
            @(negedge clk);
            exp_trig = (n == d + 1) ? en : '0;
            if (chan_trig !== exp_trig) report_mismatch("chan_trig", 64'(chan_trig), 64'(exp_trig));
            if (acq_ready !== (n == 0)) report_mismatch("acq_ready", 64'(acq_ready), 64'(n == 0));
        end
        @(posedge clk);
        chan_dones <= 5'b00111; // bit 4 missing, bit 0 not enabled
        repeat (3) begin
            @(negedge clk);
            if (acq_ready !== 1'b0) report_mismatch("acq_ready", 64'(acq_ready), 64'd0);
        end
        @(posedge clk);
        chan_dones <= en;
        @(negedge clk);
        if (acq_ready !== 1'b0) report_mismatch("acq_ready", 64'(acq_ready), 64'd0);
        @(negedge clk);
        if (acq_ready !== 1'b1) report_mismatch("acq_ready", 64'(acq_ready), 64'd1);
        @(posedge clk);
        chan_dones <= '0;
        wait_drained();
    endtask

    task automatic test_ttc_records();
        int k;
        @(posedge clk);
        chan_en    <= '0; // done at once
        trig_delay <= delay_t'(rand_bits(2));
        for (k = 0; k < 4; k++) begin
            fire_ttc(trig_type_t'(rand_bits(5)), 1'b1);
            wait_acq_ready();
        end
        wait_drained();
    endtask

    task automatic test_rate_error();
        @(posedge clk);
        trig_delay <= 16'd4;
        fire_ttc(5'h11, 1'b1);
        fire_ttc(5'h12, 1'b0); // controller still busy
        @(negedge clk);
        if (error_trig_rate !== 1'b1) begin
            report_mismatch("error_trig_rate", 64'(error_trig_rate), 64'd1);
        end
        wait_acq_ready();
        fire_ttc(5'h13, 1'b1); // number carries on from the last accepted one
        wait_acq_ready();
        wait_drained();
        if (error_trig_rate !== 1'b1) begin
            report_mismatch("error_trig_rate", 64'(error_trig_rate), 64'd1);
        end
    endtask

    task automatic test_pulses();
        int k;
        @(posedge clk);
        fp_trig_width         <= 4'd5;
        accept_pulse_triggers <= 1'b1;
        for (k = 0; k < 6; k++) begin
            send_pulse(1 + int'(rand_bits(3)), 1'b1);
            wait_drained();
        end
        @(posedge clk);
        accept_pulse_triggers <= 1'b0;
        send_pulse(4, 1'b0);
        // a gated pulse leaves the record outputs idle
        repeat (12) begin
            @(negedge clk);
            if (rec_valid !== 1'b0) report_failure("gated pulse still made a record");
        end
        @(posedge clk);
        accept_pulse_triggers <= 1'b1;
    endtask

    task automatic test_backpressure();
        timestamp_t ts_pulse;
        trig_type_t t_pulse;
        @(posedge clk);
        rec_ready  <= 1'b0;
        chan_en    <= '0;
        trig_delay <= '0;
        // TTC and pulse start together
        @(posedge clk);
        ttc_trigger <= 1'b1;
        trig_type   <= 5'h15;
        ext_trigger <= 1'b1;
        @(negedge clk);
        ts_pulse = ts_model;
        exp_q.push_back(make_rec(SRC_TTC, ttc_num, 5'h15, ts_model));
        ttc_num++;
        @(posedge clk);
        ttc_trigger <= 1'b0;
        repeat (3) @(posedge clk);
        // second TTC lands with the pulse fall so both records turn valid together
        ttc_trigger <= 1'b1;
        trig_type   <= 5'h16;
        ext_trigger <= 1'b0;
        @(negedge clk);
        t_pulse = (4 >= int'(fp_trig_width)) ? TRIG_TYPE_PULSE_LONG : TRIG_TYPE_PULSE_SHORT;
        exp_q.push_back(make_rec(SRC_TTC, ttc_num, 5'h16, ts_model));
        ttc_num++;
        exp_q.push_back(make_rec(SRC_PULSE, pulse_num, t_pulse, ts_pulse)); // TTC wins
        pulse_num++;
        @(posedge clk);
        ttc_trigger <= 1'b0;
        wait_acq_ready();
        // queue size equals the FIFO level from here on
        while (exp_q.size() < FIFO_DEPTH) begin
            fire_ttc(trig_type_t'(rand_bits(5)), 1'b1);
            wait_acq_ready();
            if (fifo_almost_full !== (exp_q.size() >= FIFO_ALMOST_FULL)) begin
                report_mismatch("fifo_almost_full", 64'(fifo_almost_full),
                                64'(exp_q.size() >= FIFO_ALMOST_FULL));
            end
        end
        fire_ttc(5'h17, 1'b1); // held pending
        wait_acq_ready();
        fire_ttc(5'h18, 1'b0); // rejected
        send_pulse(6, 1'b1);   // held pending
        send_pulse(2, 1'b0);   // ignored
        @(negedge clk);
        if (rec_valid !== 1'b1) report_mismatch("rec_valid", 64'(rec_valid), 64'd1);
        if (fifo_almost_full !== 1'b1) begin
            report_mismatch("fifo_almost_full", 64'(fifo_almost_full), 64'd1);
        end
        @(posedge clk);
        rec_ready <= 1'b1;
        wait_drained();
        repeat (4) @(negedge clk);
        if (rec_valid !== 1'b0) report_mismatch("rec_valid", 64'(rec_valid), 64'd0);
        if (fifo_almost_full !== 1'b0) begin
            report_mismatch("fifo_almost_full", 64'(fifo_almost_full), 64'd0);
        end
    endtask

    // ----------------------------------------------------------------------
    // main sequence
    // ----------------------------------------------------------------------
    initial begin
        rst                   = 1'b1;
        ttc_trigger           = 1'b0;
        ext_trigger           = 1'b0;
        accept_pulse_triggers = 1'b0;
        trig_type             = '0;
        chan_en               = '0;
        trig_delay            = '0;
        fp_trig_width         = 4'd5;
        chan_dones            = '0;
        rec_ready             = 1'b1;
        lfsr                  = LFSR_SEED;
        ttc_num               = 24'd1;
        pulse_num             = 24'd1;
        mismatches            = 0;
        failures              = 0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        check_reset_state();
        test_fanout();
        test_ttc_records();
        test_rate_error();
        test_pulses();
        test_backpressure();
        repeat (4) @(negedge clk);
        $display("mismatches %0d, other errors %0d", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: trigger_top.f
source/trigger_pkg.sv
source/trig_record_if.sv
source/ttc_trigger_receiver.sv
source/pulse_trigger_receiver.sv
source/channel_acq_controller.sv
source/trigger_record_arbiter.sv
source/trigger_record_fifo.sv
source/trigger_top.sv
tb/tb_trigger_top.sv
